// ==== previewer_macros.svh ====
`ifndef PREVIEWER_MACROS_SVH
`define PREVIEWER_MACROS_SVH

// camera frame geometry
`define PV_RAW_WIDTH   64
`define PV_RAW_HEIGHT  48

// crop window size and reset corner (x centred)
`define PV_ROI_WIDTH   16
`define PV_ROI_HEIGHT  8
`define PV_DEFAULT_X   24
`define PV_DEFAULT_Y   0

// pixel pair buffer
`define PV_FIFO_DEPTH  32

// host command stream, addr[16] then data[32], msb first
`define PV_CMD_BYTES   6
`define PV_ADDR_CROP_X 16'h0010
`define PV_ADDR_CROP_Y 16'h0011

// "BIVFRAME"
`define PV_MAGIC       64'h42_49_56_46_52_41_4D_45

`endif

// ==== previewer_pkg.sv ====
`default_nettype none
`include "previewer_macros.svh"

package previewer_pkg;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } host_cmd_t;

    typedef enum logic [15:0] {
        ADDR_CROP_X = `PV_ADDR_CROP_X,
        ADDR_CROP_Y = `PV_ADDR_CROP_Y
    } cmd_addr_e;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } crop_corner_t;

    // one sampled pixel pair with its position
    typedef struct packed {
        logic       valid;
        logic       sof;
        coord_t     x;
        coord_t     y;
        logic [7:0] cam0;
        logic [7:0] cam1;
    } cap_pixel_t;

    typedef struct packed {
        logic       sof;
        logic [7:0] cam0;
        logic [7:0] cam1;
    } pixel_pair_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_MAGIC,
        SER_CAM0,
        SER_CAM1
    } ser_state_e;

endpackage

`default_nettype wire

// ==== host_cmd_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "previewer_macros.svh"

module host_cmd_assembler (
    input  wire logic                   clk_pll,
    input  wire logic                   sys_reset,
    input  wire logic [7:0]             byte_i,
    input  wire logic                   byte_valid_i,
    output previewer_pkg::host_cmd_t    cmd_o,
    output logic                        cmd_valid_o
);
    import previewer_pkg::*;

    host_cmd_t  shift_q;
    logic [2:0] cnt_q;

    // first byte ends up in the top of the word
    always_ff @(posedge clk_pll) begin
        if (byte_valid_i) begin
            shift_q <= {shift_q[39:0], byte_i};
        end
    end

    // byte counter, strobe follows the sixth byte
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            cnt_q       <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (byte_valid_i) begin
                if (cnt_q == 3'(`PV_CMD_BYTES - 1)) begin
                    cnt_q       <= '0;
                    cmd_valid_o <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 3'd1;
                end
            end
        end
    end

    assign cmd_o = shift_q;

endmodule

`default_nettype wire

// ==== crop_corner_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "previewer_macros.svh"

module crop_corner_regs (
    input  wire logic                   clk_pll,
    input  wire logic                   sys_reset,
    input  wire previewer_pkg::host_cmd_t cmd_i,
    input  wire logic                   cmd_valid_i,
    output previewer_pkg::crop_corner_t corner_o
);
    import previewer_pkg::*;

    // largest corner that keeps the window inside the frame
    localparam int MAX_X = `PV_RAW_WIDTH - `PV_ROI_WIDTH;
    localparam int MAX_Y = `PV_RAW_HEIGHT - `PV_ROI_HEIGHT;

    crop_corner_t corner_q;

    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            corner_q.x <= coord_t'(`PV_DEFAULT_X);
            corner_q.y <= coord_t'(`PV_DEFAULT_Y);
        end else if (cmd_valid_i) begin
            case (cmd_addr_e'(cmd_i.addr))
                ADDR_CROP_X: begin
                    if (cmd_i.data <= 32'(MAX_X)) begin
                        corner_q.x <= coord_t'(cmd_i.data);
                    end
                end
                ADDR_CROP_Y: begin
                    if (cmd_i.data <= 32'(MAX_Y)) begin
                        corner_q.y <= coord_t'(cmd_i.data);
                    end
                end
                // unknown addresses fall through
                default: ;
            endcase
        end
    end

    assign corner_o = corner_q;

    corner_in_range: assert property (@(posedge clk_pll) disable iff (sys_reset)
        (corner_q.x <= coord_t'(MAX_X)) && (corner_q.y <= coord_t'(MAX_Y)));

endmodule

`default_nettype wire

// ==== pixel_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_capture (
    input  wire logic                 clk_pll,
    input  wire logic                 sys_reset,
    input  wire logic                 vsync_i,
    input  wire logic                 hsync_i,
    input  wire logic [7:0]           cam0_d_i,
    input  wire logic [7:0]           cam1_d_i,
    output previewer_pkg::cap_pixel_t pix_o
);
    import previewer_pkg::*;

    coord_t x_q;
    coord_t y_q;
    logic   hsync_q;
    logic   sof_pending_q;

    //////////////////////////////////////////////////////////////////////
    // position counters
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            x_q           <= '0;
            y_q           <= '0;
            hsync_q       <= 1'b0;
            sof_pending_q <= 1'b0;
        end else begin
            hsync_q <= hsync_i;
            if (vsync_i) begin
                x_q           <= '0;
                y_q           <= '0;
                sof_pending_q <= 1'b1;
            end else if (hsync_i) begin
                x_q           <= x_q + coord_t'(1);
                sof_pending_q <= 1'b0;
            end else if (hsync_q) begin
                // falling hsync, next line
                x_q <= '0;
                y_q <= y_q + coord_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sampled pixel, one cycle behind the ports
    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            pix_o.valid <= 1'b0;
            pix_o.sof   <= 1'b0;
        end else begin
            pix_o.valid <= hsync_i;
            pix_o.sof   <= hsync_i & sof_pending_q;
        end
        pix_o.x    <= x_q;
        pix_o.y    <= y_q;
        pix_o.cam0 <= cam0_d_i;
        pix_o.cam1 <= cam1_d_i;
    end

endmodule

`default_nettype wire

// ==== roi_cropper.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "previewer_macros.svh"

module roi_cropper (
    input  wire logic                     clk_pll,
    input  wire logic                     sys_reset,
    input  wire previewer_pkg::cap_pixel_t   pix_i,
    input  wire previewer_pkg::crop_corner_t corner_i,
    output previewer_pkg::pixel_pair_t    pair_o,
    output logic                          push_o
);
    import previewer_pkg::*;

    logic in_x;
    logic in_y;
    logic at_corner;
    logic armed_q;
    logic armed_now;

    assign in_x = (pix_i.x >= corner_i.x) && (pix_i.x < corner_i.x + `PV_ROI_WIDTH);
    assign in_y = (pix_i.y >= corner_i.y) && (pix_i.y < corner_i.y + `PV_ROI_HEIGHT);
    assign at_corner = (pix_i.x == corner_i.x) && (pix_i.y == corner_i.y);

    // only the first window corner after a camera frame start is marked
    assign armed_now = armed_q | pix_i.sof;

    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            push_o  <= 1'b0;
            armed_q <= 1'b0;
        end else begin
            push_o <= pix_i.valid && in_x && in_y;
            if (pix_i.valid && at_corner && armed_now) begin
                armed_q <= 1'b0;
            end else begin
                armed_q <= armed_now;
            end
        end
    end

    always_ff @(posedge clk_pll) begin
        pair_o.sof  <= pix_i.valid && at_corner && armed_now;
        pair_o.cam0 <= pix_i.cam0;
        pair_o.cam1 <= pix_i.cam1;
    end

endmodule

`default_nettype wire

// ==== pixel_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_fifo #(
    parameter int DEPTH = 32
) (
    input  wire logic                      clk_pll,
    input  wire logic                      sys_reset,
    input  wire logic                      push_i,
    input  wire previewer_pkg::pixel_pair_t pair_i,
    input  wire logic                      pop_i,
    output previewer_pkg::pixel_pair_t     pair_o,
    output logic                           not_empty_o,
    output logic                           overflow_o
);
    import previewer_pkg::*;

    localparam int AW = $clog2(DEPTH);

    pixel_pair_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          full;
    logic          do_push;
    logic          do_pop;

    if ((DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("pixel_fifo DEPTH must be a power of two");
    end

    // count reaches DEPTH only when full
    assign full        = count_q[AW];
    assign not_empty_o = |count_q;
    assign do_push     = push_i && !full;
    assign do_pop      = pop_i && not_empty_o;
    assign pair_o      = mem[rd_ptr_q];

    always_ff @(posedge clk_pll) begin
        if (do_push) begin
            mem[wr_ptr_q] <= pair_i;
        end
    end

    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // sticky until reset
            if (push_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    no_pop_when_empty: assert property (@(posedge clk_pll) disable iff (sys_reset)
        pop_i |-> not_empty_o);

endmodule

`default_nettype wire

// ==== frame_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "previewer_macros.svh"

module frame_serializer (
    input  wire logic                       clk_pll,
    input  wire logic                       sys_reset,
    input  wire previewer_pkg::pixel_pair_t pair_i,
    input  wire logic                       not_empty_i,
    output logic                            pop_o,
    input  wire logic                       host_full_i,
    output logic [7:0]                      byte_o,
    output logic                            byte_valid_o
);
    import previewer_pkg::*;

    localparam logic [63:0] MAGIC = `PV_MAGIC;

    ser_state_e state_q;
    ser_state_e state_d;
    logic [2:0] idx_q;
    logic [2:0] idx_d;
    // magic already sent for the frame-start pair at the head
    logic       hdr_done_q;
    logic       hdr_done_d;

    //////////////////////////////////////////////////////////////////////
    // next state and byte out, everything holds while host is full
    always_comb begin
        state_d      = state_q;
        idx_d        = idx_q;
        hdr_done_d   = hdr_done_q;
        byte_o       = '0;
        byte_valid_o = 1'b0;
        pop_o        = 1'b0;
        if (!host_full_i) begin
            case (state_q)
                SER_IDLE: begin
                    if (not_empty_i) begin
                        if (pair_i.sof) begin
                            state_d = SER_MAGIC;
                            idx_d   = '0;
                        end else begin
                            // no frame yet, discard
                            pop_o = 1'b1;
                        end
                    end
                end
                SER_MAGIC: begin
                    byte_o       = MAGIC[8*(7 - idx_q) +: 8];
                    byte_valid_o = 1'b1;
                    idx_d        = idx_q + 3'd1;
                    if (idx_q == 3'd7) begin
                        state_d    = SER_CAM0;
                        hdr_done_d = 1'b1;
                    end
                end
                SER_CAM0: begin
                    if (not_empty_i) begin
                        if (pair_i.sof && !hdr_done_q) begin
                            state_d = SER_MAGIC;
                            idx_d   = '0;
                        end else begin
                            byte_o       = pair_i.cam0;
                            byte_valid_o = 1'b1;
                            state_d      = SER_CAM1;
                        end
                    end
                end
                SER_CAM1: begin
                    byte_o       = pair_i.cam1;
                    byte_valid_o = 1'b1;
                    pop_o        = 1'b1;
                    hdr_done_d   = 1'b0;
                    state_d      = SER_CAM0;
                end
                default: state_d = SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pll) begin
        if (sys_reset) begin
            state_q    <= SER_IDLE;
            idx_q      <= '0;
            hdr_done_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            idx_q      <= idx_d;
            hdr_done_q <= hdr_done_d;
        end
    end

    no_byte_when_full: assert property (@(posedge clk_pll) disable iff (sys_reset)
        host_full_i |-> !byte_valid_o);

endmodule

`default_nettype wire

// ==== previewer_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "previewer_macros.svh"

module previewer_top (
    input  wire logic       clk_pll,
    input  wire logic       sys_reset,
    // cameras, synchronous to clk_pll
    input  wire logic       vsync_i,
    input  wire logic       hsync_i,
    input  wire logic [7:0] cam0_d_i,
    input  wire logic [7:0] cam1_d_i,
    // host byte streams
    input  wire logic [7:0] host_byte_i,
    input  wire logic       host_valid_i,
    input  wire logic       host_full_i,
    output logic [7:0]      tx_byte_o,
    output logic            tx_valid_o,
    output logic            overflow_o
);
    import previewer_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // host command path
    host_cmd_t    cmd;
    logic         cmd_valid;
    crop_corner_t corner;

    host_cmd_assembler u_cmd_asm (
        .clk_pll     (clk_pll),
        .sys_reset   (sys_reset),
        .byte_i      (host_byte_i),
        .byte_valid_i(host_valid_i),
        .cmd_o       (cmd),
        .cmd_valid_o (cmd_valid)
    );

    crop_corner_regs u_corner (
        .clk_pll    (clk_pll),
        .sys_reset  (sys_reset),
        .cmd_i      (cmd),
        .cmd_valid_i(cmd_valid),
        .corner_o   (corner)
    );

    //////////////////////////////////////////////////////////////////////
    // capture and crop
    cap_pixel_t  cap_pix;
    pixel_pair_t crop_pair;
    logic        crop_push;

    pixel_capture u_capture (
        .clk_pll  (clk_pll),
        .sys_reset(sys_reset),
        .vsync_i  (vsync_i),
        .hsync_i  (hsync_i),
        .cam0_d_i (cam0_d_i),
        .cam1_d_i (cam1_d_i),
        .pix_o    (cap_pix)
    );

    roi_cropper u_cropper (
        .clk_pll  (clk_pll),
        .sys_reset(sys_reset),
        .pix_i    (cap_pix),
        .corner_i (corner),
        .pair_o   (crop_pair),
        .push_o   (crop_push)
    );

    //////////////////////////////////////////////////////////////////////
    // buffering and byte output
    pixel_pair_t head_pair;
    logic        fifo_not_empty;
    logic        ser_pop;

    pixel_fifo #(
        .DEPTH(`PV_FIFO_DEPTH)
    ) u_fifo (
        .clk_pll    (clk_pll),
        .sys_reset  (sys_reset),
        .push_i     (crop_push),
        .pair_i     (crop_pair),
        .pop_i      (ser_pop),
        .pair_o     (head_pair),
        .not_empty_o(fifo_not_empty),
        .overflow_o (overflow_o)
    );

    frame_serializer u_serializer (
        .clk_pll     (clk_pll),
        .sys_reset   (sys_reset),
        .pair_i      (head_pair),
        .not_empty_i (fifo_not_empty),
        .pop_o       (ser_pop),
        .host_full_i (host_full_i),
        .byte_o      (tx_byte_o),
        .byte_valid_o(tx_valid_o)
    );

endmodule

`default_nettype wire

// ==== tb_previewer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "previewer_macros.svh"

module tb_previewer;
    import previewer_pkg::*;

    localparam int LFSR_SEED  = 60800;
    localparam int WAIT_LIMIT = 4000;
    localparam int BLANK_CYC  = 40;

    logic       clk_pll;
    logic       sys_reset;
    logic       vsync_i;
    logic       hsync_i;
    logic [7:0] cam0_d_i;
    logic [7:0] cam1_d_i;
    logic [7:0] host_byte_i;
    logic       host_valid_i;
    logic       host_full_i;
    logic [7:0] tx_byte_o;
    logic       tx_valid_o;
    logic       overflow_o;

    logic [15:0]  lfsr_state;
    // 0 host ready, 1 random full, 2 always full
    int           full_mode;
    int           errors;
    int           test_base;
    int           tests_passed;
    int           tests_failed;
    crop_corner_t model_corner;
    string        magic_str;
    logic [7:0]   got_q[$];
    logic [7:0]   exp_q[$];

    previewer_top dut0 (
        .clk_pll     (clk_pll),
        .sys_reset   (sys_reset),
        .vsync_i     (vsync_i),
        .hsync_i     (hsync_i),
        .cam0_d_i    (cam0_d_i),
        .cam1_d_i    (cam1_d_i),
        .host_byte_i (host_byte_i),
        .host_valid_i(host_valid_i),
        .host_full_i (host_full_i),
        .tx_byte_o   (tx_byte_o),
        .tx_valid_o  (tx_valid_o),
        .overflow_o  (overflow_o)
    );

    always #20 clk_pll = ~clk_pll;

    // collect every byte the host would see
    always @(posedge clk_pll) begin
        if (!sys_reset && tx_valid_o === 1'b1) begin
            got_q.push_back(tx_byte_o);
            if (host_full_i) begin
                $display("error: byte sent at %0t while host_full_i was high", $time);
                errors++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // random source, 16 bit galois lfsr
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], next_bit()};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // one falling edge, host full driven here for every cycle
    task automatic next_cycle();
        @(negedge clk_pll);
        if (full_mode == 1) begin
            host_full_i = (rand_bits(2) == 8'd0);
        end else begin
            host_full_i = (full_mode == 2);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic apply_reset();
        sys_reset = 1'b1;
        repeat (3) next_cycle();
        sys_reset = 1'b0;
        model_corner.x = coord_t'(`PV_DEFAULT_X);
        model_corner.y = coord_t'(`PV_DEFAULT_Y);
    endtask

    // six bytes, address then data, msb first
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        host_cmd_t cmd;
        cmd.addr = addr;
        cmd.data = data;
        for (int i = 0; i < `PV_CMD_BYTES; i++) begin
            next_cycle();
            host_byte_i  = cmd[47 - 8*i -: 8];
            host_valid_i = 1'b1;
        end
        next_cycle();
        host_valid_i = 1'b0;
        idle_cycles(4);
        if (addr == ADDR_CROP_X && data <= `PV_RAW_WIDTH - `PV_ROI_WIDTH) begin
            model_corner.x = coord_t'(data);
        end
        if (addr == ADDR_CROP_Y && data <= `PV_RAW_HEIGHT - `PV_ROI_HEIGHT) begin
            model_corner.y = coord_t'(data);
        end
    endtask

    // one camera frame, the model appends what the host should receive
    task automatic run_frame(input bit model_on);
        logic [7:0] c0;
        logic [7:0] c1;
        bit         in_x;
        bit         in_y;
        next_cycle();
        vsync_i = 1'b1;
        if (model_on) begin
            for (int i = 0; i < 8; i++) begin
                exp_q.push_back(magic_str[i]);
            end
        end
        next_cycle();
        vsync_i = 1'b0;
        for (int y = 0; y < `PV_RAW_HEIGHT; y++) begin
            for (int x = 0; x < `PV_RAW_WIDTH; x++) begin
                next_cycle();
                c0 = rand_bits(8);
                c1 = rand_bits(8);
                hsync_i  = 1'b1;
                cam0_d_i = c0;
                cam1_d_i = c1;
                in_x = (x >= int'(model_corner.x)) &&
                       (x < int'(model_corner.x) + `PV_ROI_WIDTH);
                in_y = (y >= int'(model_corner.y)) &&
                       (y < int'(model_corner.y) + `PV_ROI_HEIGHT);
                if (model_on && in_x && in_y) begin
                    exp_q.push_back(c0);
                    exp_q.push_back(c1);
                end
            end
            next_cycle();
            hsync_i = 1'b0;
            idle_cycles(BLANK_CYC - 1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_for_bytes(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (got_q.size() < n) begin
            $display("timeout: only %0d of %0d tx bytes arrived", got_q.size(), n);
            errors++;
        end
    endtask

    task automatic check_output();
        int n;
        wait_for_bytes(exp_q.size());
        idle_cycles(20);
        if (got_q.size() != exp_q.size()) begin
            $display("error: %0d tx bytes seen, %0d expected", got_q.size(), exp_q.size());
            errors++;
        end
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            compare_byte($sformatf("tx_byte_o[%0d]", i), got_q[i], exp_q[i]);
        end
        compare_flag("overflow_o", overflow_o, 1'b0);
    endtask

    task automatic start_test();
        got_q.delete();
        exp_q.delete();
        test_base = errors;
    endtask

    task automatic end_test(input int num, input string title);
        if (errors == test_base) begin
            tests_passed++;
            $display("test %0d %s: passed", num, title);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", num, title, errors - test_base);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    initial begin
        clk_pll      = 1'b0;
        sys_reset    = 1'b1;
        vsync_i      = 1'b0;
        hsync_i      = 1'b0;
        cam0_d_i     = '0;
        cam1_d_i     = '0;
        host_byte_i  = '0;
        host_valid_i = 1'b0;
        host_full_i  = 1'b0;
        lfsr_state   = 16'(LFSR_SEED);
        full_mode    = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        magic_str    = "BIVFRAME";
        apply_reset();

        start_test();
        run_frame(1'b1);
        check_output();
        end_test(1, "default window");

        start_test();
        send_cmd(ADDR_CROP_X, 32'd40);
        send_cmd(ADDR_CROP_Y, 32'd20);
        run_frame(1'b1);
        check_output();
        end_test(2, "moved window");

        // out of range x and an unknown address
        start_test();
        send_cmd(ADDR_CROP_X, 32'd60);
        send_cmd(16'h0012, 32'd5);
        run_frame(1'b1);
        check_output();
        end_test(3, "rejected writes");

        start_test();
        full_mode = 1;
        run_frame(1'b1);
        check_output();
        full_mode = 0;
        end_test(4, "random host full");

        // host never ready, buffer must overflow
        start_test();
        full_mode = 2;
        run_frame(1'b0);
        idle_cycles(20);
        if (got_q.size() != 0) begin
            $display("error: %0d bytes sent while host was full", got_q.size());
            errors++;
        end
        compare_flag("overflow_o", overflow_o, 1'b1);
        apply_reset();
        full_mode = 0;
        idle_cycles(2);
        compare_flag("overflow_o", overflow_o, 1'b0);
        got_q.delete();
        exp_q.delete();
        run_frame(1'b1);
        check_output();
        end_test(5, "overflow and recovery");

        $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
previewer_pkg.sv
host_cmd_assembler.sv
crop_corner_regs.sv
pixel_capture.sv
roi_cropper.sv
pixel_fifo.sv
frame_serializer.sv
previewer_top.sv
tb_previewer.sv
